// ==== clk_ctrl/clk_ctrl_regs.sv ====
// apb register slave for the three divider ratio registers
// psel and penable rise together, a transfer starts when both are high
// mapped writes are forwarded to the selected divider over div_cfg_if
`timescale 1ns/100ps

module clk_ctrl_regs import clk_rst_pkg::*; (
    input  logic      sys_clk_i,
    input  logic      rstn_glob_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    div_cfg_if.ctrl   div_cfg [NUM_DIV]
);

    // WRITE is the access cycle, reads and unmapped writes also pass through it
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WAIT_ACK,
        RESP
    } state_e;

    state_e             state_q;
    state_e             state_d;
    apb_addr_t          addr_q;
    logic               write_q;
    div_val_t           wdata_q;
    apb_data_t          prdata_q;
    logic [1:0]         sel_idx;
    logic               sel_hit;
    logic               access_wr;
    logic [NUM_DIV-1:0] valid_vec;
    logic [NUM_DIV-1:0] ack_vec;
    div_val_t           cur_div [NUM_DIV];

    // decode the captured offset to a divider index
    always_comb begin
        sel_hit = 1'b1;
        sel_idx = 2'(DIV_SOC);
        case (addr_q)
            ADDR_SOC_DIV:     sel_idx = 2'(DIV_SOC);
            ADDR_CLUSTER_DIV: sel_idx = 2'(DIV_CLUSTER);
            ADDR_PER_DIV:     sel_idx = 2'(DIV_PER);
            // unmapped, completes without effect
            default:          sel_hit = 1'b0;
        endcase
    end

    // a mapped write needs the divider handshake
    assign access_wr = (state_q == WRITE) && write_q && sel_hit;

    // flatten the interface array so it can be indexed at run time
    for (genvar i = 0; i < NUM_DIV; i++) begin : g_link
        assign valid_vec[i]          = access_wr && (sel_idx == 2'(i));
        assign div_cfg[i].cfg_valid  = valid_vec[i];
        assign div_cfg[i].cfg_data   = wdata_q;
        assign ack_vec[i]            = div_cfg[i].cfg_ack;
        assign cur_div[i]            = div_cfg[i].cur_div;
    end

    // transaction sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (psel_i && penable_i) begin
                    state_d = WRITE;
                end
            end
            WRITE: begin
                // valid pulses in this cycle for a mapped write
                state_d = access_wr ? WAIT_ACK : RESP;
            end
            WAIT_ACK: begin
                if (ack_vec[sel_idx]) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                // one idle cycle always follows pready
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request capture and read data
    always_ff @(posedge sys_clk_i) begin
        if ((state_q == IDLE) && psel_i && penable_i) begin
            addr_q  <= paddr_i;
            write_q <= pwrite_i;
            // dividers only take an 8 bit ratio
            wdata_q <= pwdata_i[7:0];
        end
        if ((state_q == WRITE) && !write_q) begin
            prdata_q <= sel_hit ? apb_data_t'(cur_div[sel_idx]) : '0;
        end
    end

    assign pready_o  = (state_q == RESP);
    assign prdata_o  = prdata_q;
    // no error response in this block
    assign pslverr_o = 1'b0;

    // back to back pready would skip the mandatory idle cycle
    a_pready_single: assert property (@(posedge sys_clk_i) disable iff (!rstn_glob_i)
        pready_o |=> !pready_o);

    // only the addressed divider may see a request
    a_valid_onehot: assert property (@(posedge sys_clk_i) disable iff (!rstn_glob_i)
        $onehot0(valid_vec));

endmodule

// ==== clk_div/clk_divider.sv ====
// programmable integer clock divider running from sys_clk_i
// ratio 0 or 1 passes sys_clk_i through, N >= 2 gives a clock of period N
// low for N - N/2 cycles, then high for N/2 cycles
`timescale 1ns/100ps

module clk_divider import clk_rst_pkg::*; (
    input  logic    sys_clk_i,
    input  logic    rstn_glob_i,
    div_cfg_if.div  cfg,
    output logic    div_clk_o
);

    div_val_t div_q;
    div_val_t cnt_q;
    div_val_t cnt_nxt;
    div_val_t lo_len;
    logic     clk_q;
    logic     ack_q;
    logic     bypass;

    assign bypass = (div_q < 8'd2);

    // length of the low phase, the longer half for odd ratios
    assign lo_len = div_q - (div_q >> 1);

    // wrap after N cycles
    assign cnt_nxt = (cnt_q == div_q - 8'd1) ? '0 : cnt_q + 8'd1;

    always_ff @(posedge sys_clk_i or negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            div_q <= DIV_RESET_VAL;
            cnt_q <= '0;
            clk_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            // ack lands exactly one cycle after valid
            ack_q <= cfg.cfg_valid;
            if (cfg.cfg_valid) begin
                // new ratio, restart low with a fresh count
                div_q <= cfg.cfg_data;
                cnt_q <= '0;
                clk_q <= 1'b0;
            end else if (bypass) begin
                // counter parked while the input clock is passed on
                cnt_q <= '0;
                clk_q <= 1'b0;
            end else begin
                cnt_q <= cnt_nxt;
                clk_q <= (cnt_nxt >= lo_len);
            end
        end
    end

    assign cfg.cfg_ack = ack_q;
    assign cfg.cur_div = div_q;

    // bypass selects the raw system clock
    assign div_clk_o = bypass ? sys_clk_i : clk_q;

    // one request in flight and a single cycle ack for it
    a_ack_timing: assert property (@(posedge sys_clk_i) disable iff (!rstn_glob_i)
        cfg.cfg_valid |=> cfg.cfg_ack && !cfg.cfg_valid);

endmodule

// ==== common/clk_rst_pkg.sv ====
// shared types and constants for the clock and reset generator
// imported by wildcard in the header of every module that needs them
package clk_rst_pkg;

    // register offset inside the 4 KiB block
    typedef logic [11:0] apb_addr_t;
    // apb data word
    typedef logic [31:0] apb_data_t;
    // integer divider ratio, 0 and 1 mean bypass
    typedef logic [7:0]  div_val_t;

    // number of dividers fed from sys_clk_i
    localparam int unsigned NUM_DIV = 3;

    // divider positions in the generate loop
    localparam int unsigned DIV_SOC     = 0;
    localparam int unsigned DIV_CLUSTER = 1;
    localparam int unsigned DIV_PER     = 2;

    // register map
    localparam apb_addr_t ADDR_SOC_DIV     = 12'hF00;
    localparam apb_addr_t ADDR_CLUSTER_DIV = 12'hF08;
    localparam apb_addr_t ADDR_PER_DIV     = 12'hF10;

    // ratio after reset, divider comes up in bypass
    localparam div_val_t DIV_RESET_VAL = 8'd0;

    // flops per reset synchroniser
    localparam int unsigned RST_SYNC_STAGES = 2;

endpackage

// ==== common/div_cfg_if.sv ====
// configuration link between the register block and one clock divider
// ctrl side sends a one cycle valid, div side answers with a one cycle ack
`timescale 1ns/100ps

interface div_cfg_if import clk_rst_pkg::*; ();

    // new ratio request, single cycle pulse
    logic     cfg_valid;
    // ratio to load, low byte of the apb write data
    div_val_t cfg_data;
    // divider acknowledge, one cycle after cfg_valid
    logic     cfg_ack;
    // ratio currently in use, for readback
    div_val_t cur_div;

    modport ctrl (
        output cfg_valid,
        output cfg_data,
        input  cfg_ack,
        input  cur_div
    );

    modport div (
        input  cfg_valid,
        input  cfg_data,
        output cfg_ack,
        output cur_div
    );

endinterface

// ==== hw/clk_rst_gen_top.sv ====
// clock and reset generator top level
// apb register slave, three dividers on sys_clk_i and the reset output stage
`timescale 1ns/100ps

module clk_rst_gen_top import clk_rst_pkg::*; (
    input  logic      sys_clk_i,
    input  logic      rstn_glob_i,
    // apb slave port
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    // generated clocks and resets
    output logic      clk_soc_o,
    output logic      clk_cluster_o,
    output logic      clk_per_o,
    output logic      rstn_soc_sync_o,
    output logic      rstn_cluster_sync_o
);

    // raw divider outputs, ordered by divider index
    logic [NUM_DIV-1:0] div_clk;

    // one config link per divider
    div_cfg_if div_cfg [NUM_DIV] ();

    clk_ctrl_regs u_regs (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .div_cfg     (div_cfg)
    );

    // soc, cluster and peripheral dividers
    for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
        clk_divider u_div (
            .sys_clk_i   (sys_clk_i),
            .rstn_glob_i (rstn_glob_i),
            .cfg         (div_cfg[i]),
            .div_clk_o   (div_clk[i])
        );
    end

    clk_rst_out u_out (
        .rstn_glob_i         (rstn_glob_i),
        .div_clk_i           (div_clk),
        .clk_soc_o           (clk_soc_o),
        .clk_cluster_o       (clk_cluster_o),
        .clk_per_o           (clk_per_o),
        .rstn_soc_sync_o     (rstn_soc_sync_o),
        .rstn_cluster_sync_o (rstn_cluster_sync_o)
    );

endmodule

// ==== hw/clk_rst_out.sv ====
// output stage for the divided clocks and the domain resets
// soc and cluster resets assert asynchronously and release on their own clock
`timescale 1ns/100ps

module clk_rst_out import clk_rst_pkg::*; (
    input  logic               rstn_glob_i,
    input  logic [NUM_DIV-1:0] div_clk_i,
    output logic               clk_soc_o,
    output logic               clk_cluster_o,
    output logic               clk_per_o,
    output logic               rstn_soc_sync_o,
    output logic               rstn_cluster_sync_o
);

    // synchronised domain resets with soc in bit 0 and cluster in bit 1
    logic [1:0] rstn_sync;

    assign clk_soc_o     = div_clk_i[DIV_SOC];
    assign clk_cluster_o = div_clk_i[DIV_CLUSTER];
    assign clk_per_o     = div_clk_i[DIV_PER];

    // soc and cluster sit at indices 0 and 1, so the loop walks both
    for (genvar d = 0; d < 2; d++) begin : g_sync
        // shift chain of this domain
        logic [RST_SYNC_STAGES-1:0] sync_q;

        always_ff @(posedge div_clk_i[d] or negedge rstn_glob_i) begin
            if (!rstn_glob_i) begin
                sync_q <= '0;
            end else begin
                // a one shifts in and reaches the top after RST_SYNC_STAGES edges
                sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
            end
        end

        assign rstn_sync[d] = sync_q[RST_SYNC_STAGES-1];

        // global reset must always reach the domain reset
        a_rst_follow: assert property (@(posedge div_clk_i[d])
            !rstn_glob_i |-> !rstn_sync[d]);
    end

    assign rstn_soc_sync_o     = rstn_sync[DIV_SOC];
    assign rstn_cluster_sync_o = rstn_sync[DIV_CLUSTER];

endmodule

// ==== project.f ====
common/clk_rst_pkg.sv
common/div_cfg_if.sv
clk_ctrl/clk_ctrl_regs.sv
clk_div/clk_divider.sv
hw/clk_rst_out.sv
hw/clk_rst_gen_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the clock and reset generator testbench with verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f project.f -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
exit 1

// ==== tests/tb_checker.sv ====
// monitor and scoreboard for the clock and reset generator
// samples apb on the falling clock edge, times the output clocks and the reset release
// error and check counts leave on ports for the closing report in tb_top
`timescale 1ns/100ps

module tb_checker import clk_rst_pkg::*; (
    input  logic      sys_clk_i,
    input  logic      rstn_glob_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  apb_data_t prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i,
    input  logic      clk_soc_i,
    input  logic      clk_cluster_i,
    input  logic      clk_per_i,
    input  logic      rstn_soc_sync_i,
    input  logic      rstn_cluster_sync_i,
    input  logic      final_i,
    output int        err_cnt_o,
    output int        chk_cnt_o
);

    // sys_clk_i period in ns
    localparam realtime CLK_NS = 40.0;

    logic [NUM_DIV-1:0] clk_vec;
    logic [1:0]         dom_clk;
    logic [1:0]         dom_rstn;
    // ratio model, one entry per divider
    div_val_t           model [NUM_DIV] = '{default: '0};
    // set while a divider is being reprogrammed
    logic [NUM_DIV-1:0] quiet_q = '0;
    realtime            arm_t [NUM_DIV] = '{default: 0.0};
    realtime            exp_ns [NUM_DIV] = '{default: 40.0};
    realtime            rel_t = 0.0;
    logic               rel_seen = 1'b0;
    int                 main_err = 0;
    int                 main_chk = 0;
    // open transfer
    logic               busy = 1'b0;
    int                 cyc = 0;
    int                 exp_cyc = 0;
    logic               cur_wr = 1'b0;
    logic               cur_hit = 1'b0;
    logic [1:0]         cur_sel = '0;
    div_val_t           cur_data = '0;
    apb_addr_t          cur_addr = '0;
    logic               final_done = 1'b0;

    assign clk_vec  = {clk_per_i, clk_cluster_i, clk_soc_i};
    assign dom_clk  = {clk_cluster_i, clk_soc_i};
    assign dom_rstn = {rstn_cluster_sync_i, rstn_soc_sync_i};

    // register map as given for the block, -1 for unmapped
    function automatic int offset_index(apb_addr_t addr);
        int idx;
        idx = -1;
        if (addr == ADDR_SOC_DIV) idx = 0;
        if (addr == ADDR_CLUSTER_DIV) idx = 1;
        if (addr == ADDR_PER_DIV) idx = 2;
        return idx;
    endfunction

    // 0 and 1 mean bypass, so the output runs at the system clock
    function automatic realtime period_for(div_val_t ratio);
        if (ratio < 8'd2) return CLK_NS;
        return CLK_NS * real'(ratio);
    endfunction

    function automatic string clk_name(int c);
        case (c)
            0:       return "clk_soc_o";
            1:       return "clk_cluster_o";
            default: return "clk_per_o";
        endcase
    endfunction

    task automatic check_val(input string name, input apb_data_t exp_v, input apb_data_t act_v);
        main_chk++;
        if (exp_v != act_v) begin
            main_err++;
            $display("[ERROR] t=%0.1f ns %s expected %0h actual %0h",
                     $realtime, name, exp_v, act_v);
        end
    endtask

    // apb protocol, read data and the reset level during reset
    always @(negedge sys_clk_i) begin
        apb_data_t exp_rd;
        exp_rd = '0;
        check_val("pslverr_o", '0, apb_data_t'(pslverr_i));
        if (!rstn_glob_i) begin
            check_val("rstn_soc_sync_o", '0, apb_data_t'(rstn_soc_sync_i));
            check_val("rstn_cluster_sync_o", '0, apb_data_t'(rstn_cluster_sync_i));
        end
        if (busy) begin
            cyc++;
            if (pready_i) begin
                check_val("pready_o latency", apb_data_t'(exp_cyc), apb_data_t'(cyc));
                if (!cur_wr) begin
                    // zero extended ratio, zero for an unmapped offset
                    if (cur_hit) exp_rd = apb_data_t'(model[cur_sel]);
                    check_val("prdata_o", exp_rd, prdata_i);
                end else if (cur_hit) begin
                    model[cur_sel]   = cur_data;
                    exp_ns[cur_sel]  = period_for(cur_data);
                    arm_t[cur_sel]   = $realtime;
                    quiet_q[cur_sel] = 1'b0;
                end
                busy = 1'b0;
            end else if (cyc >= exp_cyc) begin
                main_err++;
                $display("pready_o did not come within %0d cycles for offset %h at %0.1f ns",
                         exp_cyc, cur_addr, $realtime);
                busy = 1'b0;
            end
        end else if (pready_i) begin
            main_err++;
            $display("pready_o went high with no transfer open at %0.1f ns", $realtime);
        end else if (psel_i && penable_i) begin
            // the dut captures this request on the next rising edge
            busy     = 1'b1;
            cyc      = 0;
            cur_addr = paddr_i;
            cur_wr   = pwrite_i;
            cur_data = pwdata_i[7:0];
            cur_hit  = (offset_index(paddr_i) >= 0);
            cur_sel  = 2'(offset_index(paddr_i));
            exp_cyc  = (cur_wr && cur_hit) ? 3 : 2;
            if (cur_wr && cur_hit) quiet_q[cur_sel] = 1'b1;
        end
        if (final_i && !final_done) begin
            final_done = 1'b1;
            if (busy) begin
                main_err++;
                $display("a transfer to offset %h was still open at the end", cur_addr);
            end
            check_val("rstn_soc_sync_o", 32'd1, apb_data_t'(rstn_soc_sync_i));
            check_val("rstn_cluster_sync_o", 32'd1, apb_data_t'(rstn_cluster_sync_i));
        end
    end

    always @(posedge rstn_glob_i) begin
        rel_t    = $realtime;
        rel_seen = 1'b1;
    end

    // rising edge spacing of each output clock
    for (genvar c = 0; c < NUM_DIV; c++) begin : g_clk
        realtime last_t = 0.0;
        realtime gap = 0.0;
        logic    have_ref = 1'b0;
        int      clk_err = 0;
        int      clk_chk = 0;

        always @(posedge clk_vec[c]) begin
            gap = $realtime - last_t;
            if (quiet_q[c]) begin
                have_ref = 1'b0;
            end else if (!have_ref || (last_t < arm_t[c])) begin
                // first edge in the new setting is the reference
                have_ref = 1'b1;
                last_t   = $realtime;
            end else begin
                clk_chk++;
                if ((gap - exp_ns[c] > 0.05) || (exp_ns[c] - gap > 0.05)) begin
                    clk_err++;
                    $display("[ERROR] t=%0.1f ns %s period expected %0.1f ns actual %0.1f ns",
                             $realtime, clk_name(c), exp_ns[c], gap);
                end
                last_t = $realtime;
            end
        end
    end

    // release on the second domain clock edge after rstn_glob_i rises
    for (genvar d = 0; d < 2; d++) begin : g_rst
        int   edges = 0;
        int   rst_err = 0;
        int   rst_chk = 0;

        always @(posedge dom_clk[d]) begin
            if (rel_seen && ($realtime > rel_t)) edges++;
        end

        always @(posedge dom_rstn[d]) begin
            rst_chk++;
            if (edges != 2) begin
                rst_err++;
                $display("[ERROR] t=%0.1f ns %s release edge expected 2 actual %0d",
                         $realtime, (d == 0) ? "rstn_soc_sync_o" : "rstn_cluster_sync_o",
                         edges);
            end
        end
    end

    assign err_cnt_o = main_err + g_clk[0].clk_err + g_clk[1].clk_err + g_clk[2].clk_err
                     + g_rst[0].rst_err + g_rst[1].rst_err;
    assign chk_cnt_o = main_chk + g_clk[0].clk_chk + g_clk[1].clk_chk + g_clk[2].clk_chk
                     + g_rst[0].rst_chk + g_rst[1].rst_chk;

endmodule

// ==== tests/tb_top.sv ====
// testbench top for the clock and reset generator
// seeded random apb reads and writes into the dut, tb_checker compares the results
`timescale 1ns/100ps

module tb_top import clk_rst_pkg::*; ();

    localparam int NUM_TXN     = 200;
    // longest transfer plus idle stays below 80 cycles
    localparam int TIMEOUT_CYC = NUM_TXN * 80 + 500;

    logic      sys_clk;
    logic      rstn_glob;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      clk_soc;
    logic      clk_cluster;
    logic      clk_per;
    logic      rstn_soc_sync;
    logic      rstn_cluster_sync;
    logic      final_chk;
    int        err_cnt;
    int        chk_cnt;
    int        cyc_cnt;

    clk_rst_gen_top u_dut (
        .sys_clk_i           (sys_clk),
        .rstn_glob_i         (rstn_glob),
        .psel_i              (psel),
        .penable_i           (penable),
        .pwrite_i            (pwrite),
        .paddr_i             (paddr),
        .pwdata_i            (pwdata),
        .prdata_o            (prdata),
        .pready_o            (pready),
        .pslverr_o           (pslverr),
        .clk_soc_o           (clk_soc),
        .clk_cluster_o       (clk_cluster),
        .clk_per_o           (clk_per),
        .rstn_soc_sync_o     (rstn_soc_sync),
        .rstn_cluster_sync_o (rstn_cluster_sync)
    );

    tb_checker u_chk (
        .sys_clk_i           (sys_clk),
        .rstn_glob_i         (rstn_glob),
        .psel_i              (psel),
        .penable_i           (penable),
        .pwrite_i            (pwrite),
        .paddr_i             (paddr),
        .pwdata_i            (pwdata),
        .prdata_i            (prdata),
        .pready_i            (pready),
        .pslverr_i           (pslverr),
        .clk_soc_i           (clk_soc),
        .clk_cluster_i       (clk_cluster),
        .clk_per_i           (clk_per),
        .rstn_soc_sync_i     (rstn_soc_sync),
        .rstn_cluster_sync_i (rstn_cluster_sync),
        .final_i             (final_chk),
        .err_cnt_o           (err_cnt),
        .chk_cnt_o           (chk_cnt)
    );

    // 40 ns system clock
    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    function automatic apb_addr_t pick_offset(int unsigned kind);
        apb_addr_t a;
        case (kind)
            0:       a = ADDR_SOC_DIV;
            1:       a = ADDR_CLUSTER_DIV;
            2:       a = ADDR_PER_DIV;
            default: a = ADDR_SOC_DIV;
        endcase
        return a;
    endfunction

    // half of the unmapped offsets land close to the register map
    function automatic apb_addr_t pick_unmapped();
        apb_addr_t a;
        a = ADDR_SOC_DIV;
        while (a == ADDR_SOC_DIV || a == ADDR_CLUSTER_DIV || a == ADDR_PER_DIV) begin
            if ($urandom_range(1, 0) == 1) a = 12'hF00 + 12'($urandom_range(31, 0));
            else a = apb_addr_t'($urandom());
        end
        return a;
    endfunction

    // psel and penable rise together and drop the cycle after pready
    task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t data);
        @(posedge sys_clk);
        psel    <= 1'b1;
        penable <= 1'b1;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        // pready looked at mid-cycle
        @(negedge sys_clk);
        while (!pready) begin
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial begin
        int unsigned seed_val;
        int unsigned kind;
        int unsigned ratio;
        int          n;
        logic        wr;
        apb_addr_t   addr;
        apb_data_t   data;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        final_chk = 1'b0;
        rstn_glob = 1'b0;
        seed_val  = $urandom(52);
        repeat (5) @(posedge sys_clk);
        rstn_glob <= 1'b1;
        repeat (4) @(posedge sys_clk);
        for (n = 0; n < NUM_TXN; n++) begin
            kind  = $urandom_range(3, 0);
            wr    = 1'($urandom_range(1, 0));
            ratio = $urandom_range(20, 0);
            addr  = (kind == 3) ? pick_unmapped() : pick_offset(kind);
            // upper bytes are noise, only the low byte is a ratio
            data  = ($urandom() & 32'hFFFF_FF00) | 32'(ratio);
            apb_transfer(addr, wr, data);
            // room for a few periods of the new clock
            if (wr) repeat (3 * ratio + 8) @(posedge sys_clk);
            else repeat (3) @(posedge sys_clk);
        end
        final_chk <= 1'b1;
        repeat (2) @(posedge sys_clk);
        $display("checks: %0d  errors: %0d  seed: 52", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // cycle limit so the run always ends
    initial begin
        cyc_cnt = 0;
        while (cyc_cnt < TIMEOUT_CYC) begin
            @(posedge sys_clk);
            cyc_cnt++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("TEST FAIL");
        $finish;
    end

endmodule
